// ==== verilog/dso_macros.svh ====
// dso shared constants
`ifndef DSO_MACROS_SVH
`define DSO_MACROS_SVH

// samples stored per captured frame
`define DSO_CAPTURE_DEPTH 256

// wishbone register word addresses
`define DSO_REG_CTRL       9'd0
`define DSO_REG_TRIG_LEVEL 9'd1
`define DSO_REG_DECI_RATE  9'd2
`define DSO_REG_STATUS     9'd3
`define DSO_REG_MEASURE    9'd4

// first word of the frame buffer read window
`define DSO_BUF_BASE 9'd256

`endif

// ==== verilog/dso_pkg.sv ====
// dso shared types
package dso_pkg;

  typedef logic [7:0] sample_t;     // unsigned adc code
  typedef logic [7:0] buf_addr_t;   // frame buffer index
  typedef logic [9:0] deci_rate_t;  // keep one of every rate+1 samples

  typedef enum logic {
    EDGE_RISE = 1'b0,
    EDGE_FALL = 1'b1
  } trig_edge_e;

  // layout matches the MEASURE register
  typedef struct packed {
    sample_t max;  // bits 23:16
    sample_t min;  // bits 15:8
    sample_t vpp;  // bits 7:0
  } measure_t;

endpackage

// ==== verilog/mem_req_if.sv ====
// sample buffer access port
`timescale 1ns/1ps

interface mem_req_if import dso_pkg::*; ();

  logic      req;     // transfer wanted
  logic      we;      // write when set
  buf_addr_t addr;
  sample_t   wdata;
  logic      gnt;     // same cycle grant
  sample_t   rdata;
  logic      rvalid;  // one cycle after a granted read

  // requester holds req and its fields until gnt
  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata,
    input  rvalid
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata,
    output rvalid
  );

endinterface

// ==== verilog/decimator.sv ====
// sample rate decimator
`timescale 1ns/1ps

module decimator import dso_pkg::*; (
  input  logic       i_ad_clk,
  input  logic       i_rst,
  input  deci_rate_t i_deci_rate,  // 0 keeps every sample
  output logic       o_deci_valid
);

  deci_rate_t deci_cnt;  // runs 0..i_deci_rate

  always_ff @(posedge i_ad_clk) begin
    if (i_rst) begin
      deci_cnt <= '0;
    end else if (deci_cnt >= i_deci_rate) begin  // also catches a lowered rate
      deci_cnt <= '0;
    end else begin
      deci_cnt <= deci_cnt + 1'b1;
    end
  end

  assign o_deci_valid = (deci_cnt == '0);

endmodule

// ==== verilog/trig_capture.sv ====
// edge trigger and frame capture
`timescale 1ns/1ps
`include "dso_macros.svh"

module trig_capture import dso_pkg::*; (
  input  logic         i_ad_clk,
  input  logic         i_rst,
  input  sample_t      i_ad_data,
  input  logic         i_deci_valid,
  input  logic         i_arm,         // one cycle pulse
  input  logic         i_stop,        // one cycle pulse
  input  sample_t      i_trig_level,
  input  trig_edge_e   i_trig_edge,
  mem_req_if.requester cap_bus,
  output logic         o_frame_start,
  output logic         o_frame_sample_valid,
  output logic         o_done
);

  localparam int CNT_W = $clog2(`DSO_CAPTURE_DEPTH) + 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_CAPTURE
  } state_e;

  state_e           state;
  logic             have_prev;    // previous decimated sample seen
  sample_t          prev_sample;
  logic [CNT_W-1:0] wr_cnt;       // frame samples issued so far
  logic             step;         // decimated sample not masked by arm/stop
  logic             trig_hit;
  logic             wr_fire;
  logic             last_wr;

  assign step = i_deci_valid && !i_arm && !i_stop;

  assign trig_hit = (i_trig_edge == EDGE_RISE) ?
                    (prev_sample < i_trig_level && i_ad_data >= i_trig_level) :
                    (prev_sample >= i_trig_level && i_ad_data < i_trig_level);

  assign o_frame_start        = step && state == ST_ARMED && have_prev && trig_hit;
  assign wr_fire              = o_frame_start || (step && state == ST_CAPTURE);
  assign o_frame_sample_valid = wr_fire;
  assign last_wr = wr_fire && wr_cnt == CNT_W'(`DSO_CAPTURE_DEPTH - 1);

  always_ff @(posedge i_ad_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      have_prev <= 1'b0;
      wr_cnt    <= '0;
      o_done    <= 1'b0;
    end else if (i_stop) begin
      state <= ST_IDLE;
    end else if (i_arm) begin
      state     <= ST_ARMED;
      have_prev <= 1'b0;
      wr_cnt    <= '0;
      o_done    <= 1'b0;
    end else begin
      if (step && state == ST_ARMED) have_prev <= 1'b1;
      if (wr_fire) wr_cnt <= wr_cnt + 1'b1;
      if (o_frame_start) state <= ST_CAPTURE;
      if (last_wr) begin  // frame complete
        state  <= ST_IDLE;
        o_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_ad_clk) begin
    if (state == ST_ARMED && i_deci_valid) prev_sample <= i_ad_data;
  end

  // one buffer write per frame sample
  always_ff @(posedge i_ad_clk) begin
    if (i_rst) begin
      cap_bus.req <= 1'b0;
    end else if (wr_fire) begin
      cap_bus.req <= 1'b1;
    end else if (cap_bus.gnt) begin
      cap_bus.req <= 1'b0;
    end
  end

  always_ff @(posedge i_ad_clk) begin
    if (wr_fire) begin
      cap_bus.addr  <= buf_addr_t'(wr_cnt);
      cap_bus.wdata <= i_ad_data;
    end
  end

  assign cap_bus.we = 1'b1;  // capture only writes

  a_no_overrun : assert property (@(posedge i_ad_clk) disable iff (i_rst)
    wr_fire |-> !(cap_bus.req && !cap_bus.gnt))
    else $error("capture sample issued over an ungranted write");

  a_addr_range : assert property (@(posedge i_ad_clk) disable iff (i_rst)
    wr_fire |-> wr_cnt <= CNT_W'(`DSO_CAPTURE_DEPTH - 1))
    else $error("capture write address past frame end");

endmodule

// ==== verilog/param_measure.sv ====
// frame max min and vpp
`timescale 1ns/1ps

module param_measure import dso_pkg::*; (
  input  logic     i_ad_clk,
  input  logic     i_rst,
  input  sample_t  i_ad_data,
  input  logic     i_frame_start,
  input  logic     i_frame_sample_valid,
  input  logic     i_done,
  output measure_t o_measure
);

  sample_t  run_max;
  sample_t  run_min;
  logic     done_q;
  logic     done_rise;
  measure_t live;
  measure_t meas_q;  // result of the last finished frame

  assign done_rise = i_done && !done_q;

  assign live.max = run_max;
  assign live.min = run_min;
  assign live.vpp = run_max - run_min;

  always_ff @(posedge i_ad_clk) begin
    if (i_frame_sample_valid) begin
      if (i_frame_start || i_ad_data > run_max) run_max <= i_ad_data;  // first sample seeds
      if (i_frame_start || i_ad_data < run_min) run_min <= i_ad_data;
    end
  end

  always_ff @(posedge i_ad_clk) begin
    if (i_rst) begin
      done_q <= 1'b0;
      meas_q <= '0;
    end else begin
      done_q <= i_done;
      if (done_rise) meas_q <= live;
    end
  end

  // bypass so the result is already visible in the cycle done rises
  assign o_measure = done_rise ? live : meas_q;

endmodule

// ==== verilog/sample_arbiter.sv ====
// fixed priority buffer arbiter
`timescale 1ns/1ps

module sample_arbiter import dso_pkg::*; (
  input  logic       i_ad_clk,
  input  logic       i_rst,
  mem_req_if.arbiter cap_bus,   // high priority
  mem_req_if.arbiter host_bus,  // served in idle capture cycles
  output logic       o_ram_en,
  output logic       o_ram_we,
  output buf_addr_t  o_ram_addr,
  output sample_t    o_ram_wdata,
  input  sample_t    i_ram_rdata
);

  logic cap_rd_q;   // capture owns the read in flight
  logic host_rd_q;  // host owns the read in flight

  assign cap_bus.gnt  = cap_bus.req;
  assign host_bus.gnt = host_bus.req && !cap_bus.req;

  assign o_ram_en    = cap_bus.gnt || host_bus.gnt;
  assign o_ram_we    = cap_bus.gnt ? cap_bus.we : (host_bus.gnt && host_bus.we);
  assign o_ram_addr  = cap_bus.gnt ? cap_bus.addr : host_bus.addr;
  assign o_ram_wdata = cap_bus.gnt ? cap_bus.wdata : host_bus.wdata;

  always_ff @(posedge i_ad_clk) begin
    if (i_rst) begin
      cap_rd_q  <= 1'b0;
      host_rd_q <= 1'b0;
    end else begin
      cap_rd_q  <= cap_bus.gnt && !cap_bus.we;
      host_rd_q <= host_bus.gnt && !host_bus.we;
    end
  end

  assign cap_bus.rdata   = i_ram_rdata;
  assign cap_bus.rvalid  = cap_rd_q;
  assign host_bus.rdata  = i_ram_rdata;
  assign host_bus.rvalid = host_rd_q;

  // a waiting host keeps its request until served
  a_host_held : assert property (@(posedge i_ad_clk) disable iff (i_rst)
    host_bus.req && !host_bus.gnt |=> host_bus.req && $stable(host_bus.addr))
    else $error("host request changed before its grant");

endmodule

// ==== verilog/sample_ram.sv ====
// frame sample buffer
`timescale 1ns/1ps
`include "dso_macros.svh"

module sample_ram import dso_pkg::*; (
  input  logic      i_ad_clk,
  input  logic      i_ram_en,
  input  logic      i_ram_we,
  input  buf_addr_t i_ram_addr,
  input  sample_t   i_ram_wdata,
  output sample_t   o_ram_rdata  // valid one cycle after a read
);

  sample_t mem [`DSO_CAPTURE_DEPTH];

  always_ff @(posedge i_ad_clk) begin
    if (i_ram_en) begin
      if (i_ram_we) begin
        mem[i_ram_addr] <= i_ram_wdata;
      end else begin
        o_ram_rdata <= mem[i_ram_addr];
      end
    end
  end

endmodule

// ==== verilog/wb_regs.sv ====
// wishbone register file
`timescale 1ns/1ps
`include "dso_macros.svh"

module wb_regs import dso_pkg::*; (
  input  logic         i_ad_clk,
  input  logic         i_rst,
  input  logic         i_wb_cyc,
  input  logic         i_wb_stb,
  input  logic         i_wb_we,
  input  logic [8:0]   i_wb_adr,
  input  logic [31:0]  i_wb_dat,
  output logic [31:0]  o_wb_dat,
  output logic         o_wb_ack,
  mem_req_if.requester host_bus,
  input  logic         i_done,
  input  measure_t     i_measure,
  output sample_t      o_trig_level,
  output trig_edge_e   o_trig_edge,
  output deci_rate_t   o_deci_rate,
  output logic         o_arm,
  output logic         o_stop
);

  logic        ctrl_run;
  logic        done_q;
  logic        ack_q;      // register and dummy accesses
  logic [31:0] dat_q;
  logic        rd_pend;    // buffer read in flight
  logic        wb_new;     // access not yet being served
  logic        buf_hit;
  logic        buf_rd;
  logic        ctrl_wr;
  logic [31:0] reg_rdata;

  assign wb_new  = i_wb_cyc && i_wb_stb && !o_wb_ack && !rd_pend;
  assign buf_hit = i_wb_adr >= `DSO_BUF_BASE;
  assign buf_rd  = wb_new && buf_hit && !i_wb_we;
  assign ctrl_wr = wb_new && i_wb_we && i_wb_adr == `DSO_REG_CTRL;

  always_comb begin
    case (i_wb_adr)
      `DSO_REG_CTRL:       reg_rdata = {30'd0, o_trig_edge, ctrl_run};
      `DSO_REG_TRIG_LEVEL: reg_rdata = {24'd0, o_trig_level};
      `DSO_REG_DECI_RATE:  reg_rdata = {22'd0, o_deci_rate};
      `DSO_REG_STATUS:     reg_rdata = {31'd0, i_done};
      `DSO_REG_MEASURE:    reg_rdata = {8'd0, i_measure};
      default:             reg_rdata = 32'd0;  // unmapped
    endcase
  end

  always_ff @(posedge i_ad_clk) begin
    if (i_rst) begin
      ctrl_run     <= 1'b0;
      o_trig_edge  <= EDGE_RISE;
      o_trig_level <= '0;
      o_deci_rate  <= '0;
      done_q       <= 1'b0;
      o_arm        <= 1'b0;
      o_stop       <= 1'b0;
    end else begin
      done_q <= i_done;
      o_arm  <= ctrl_wr && i_wb_dat[0];
      o_stop <= ctrl_wr && !i_wb_dat[0];
      if (i_done && !done_q) ctrl_run <= 1'b0;  // frame finished
      if (wb_new && i_wb_we) begin
        case (i_wb_adr)
          `DSO_REG_CTRL: begin
            ctrl_run    <= i_wb_dat[0];
            o_trig_edge <= trig_edge_e'(i_wb_dat[1]);
          end
          `DSO_REG_TRIG_LEVEL: o_trig_level <= i_wb_dat[7:0];
          `DSO_REG_DECI_RATE:  o_deci_rate  <= i_wb_dat[9:0];
          default: ;  // read only, buffer or unmapped
        endcase
      end
    end
  end

  always_ff @(posedge i_ad_clk) begin
    if (i_rst) begin
      ack_q        <= 1'b0;
      rd_pend      <= 1'b0;
      host_bus.req <= 1'b0;
    end else begin
      ack_q <= wb_new && !buf_rd;
      if (buf_rd) rd_pend <= 1'b1;
      else if (host_bus.rvalid) rd_pend <= 1'b0;
      if (buf_rd) host_bus.req <= 1'b1;
      else if (host_bus.gnt) host_bus.req <= 1'b0;
    end
  end

  always_ff @(posedge i_ad_clk) begin
    if (wb_new) dat_q <= (buf_hit || i_wb_we) ? 32'd0 : reg_rdata;
    if (buf_rd) host_bus.addr <= buf_addr_t'(i_wb_adr - `DSO_BUF_BASE);
  end

  assign host_bus.we    = 1'b0;  // host side only reads
  assign host_bus.wdata = '0;

  // buffer reads finish whenever the arbiter returns data
  assign o_wb_ack = ack_q || (rd_pend && host_bus.rvalid);
  assign o_wb_dat = host_bus.rvalid ? {24'd0, host_bus.rdata} : dat_q;

  a_ack_in_cycle : assert property (@(posedge i_ad_clk) disable iff (i_rst)
    o_wb_ack |-> i_wb_cyc && i_wb_stb)
    else $error("wishbone ack outside a bus cycle");

endmodule

// ==== verilog/dso_core.sv ====
// dso acquisition core
`timescale 1ns/1ps

module dso_core import dso_pkg::*; (
  input  logic        i_ad_clk,        // adc sample clock
  input  logic        i_rst,
  input  logic [7:0]  i_ad_data,       // raw adc code
  input  logic        i_wb_cyc,
  input  logic        i_wb_stb,
  input  logic        i_wb_we,
  input  logic [8:0]  i_wb_adr,        // word address
  input  logic [31:0] i_wb_dat,
  output logic [31:0] o_wb_dat,
  output logic        o_wb_ack,
  output logic        o_capture_done   // host interrupt
);

  deci_rate_t deci_rate;
  logic       deci_valid;
  sample_t    trig_level;
  trig_edge_e trig_edge;
  logic       arm;
  logic       stop;
  logic       frame_start;
  logic       frame_sample_valid;
  logic       done;
  measure_t   measure;
  logic       ram_en;
  logic       ram_we;
  buf_addr_t  ram_addr;
  sample_t    ram_wdata;
  sample_t    ram_rdata;

  mem_req_if cap_bus ();   // capture writer to arbiter
  mem_req_if host_bus ();  // host reader to arbiter

  decimator u_decimator (
    .i_ad_clk    (i_ad_clk),
    .i_rst       (i_rst),
    .i_deci_rate (deci_rate),
    .o_deci_valid(deci_valid)
  );

  trig_capture u_trig_capture (
    .i_ad_clk            (i_ad_clk),
    .i_rst               (i_rst),
    .i_ad_data           (i_ad_data),
    .i_deci_valid        (deci_valid),
    .i_arm               (arm),
    .i_stop              (stop),
    .i_trig_level        (trig_level),
    .i_trig_edge         (trig_edge),
    .cap_bus             (cap_bus),
    .o_frame_start       (frame_start),
    .o_frame_sample_valid(frame_sample_valid),
    .o_done              (done)
  );

  param_measure u_param_measure (
    .i_ad_clk            (i_ad_clk),
    .i_rst               (i_rst),
    .i_ad_data           (i_ad_data),
    .i_frame_start       (frame_start),
    .i_frame_sample_valid(frame_sample_valid),
    .i_done              (done),
    .o_measure           (measure)
  );

  sample_arbiter u_sample_arbiter (
    .i_ad_clk   (i_ad_clk),
    .i_rst      (i_rst),
    .cap_bus    (cap_bus),
    .host_bus   (host_bus),
    .o_ram_en   (ram_en),
    .o_ram_we   (ram_we),
    .o_ram_addr (ram_addr),
    .o_ram_wdata(ram_wdata),
    .i_ram_rdata(ram_rdata)
  );

  sample_ram u_sample_ram (
    .i_ad_clk   (i_ad_clk),
    .i_ram_en   (ram_en),
    .i_ram_we   (ram_we),
    .i_ram_addr (ram_addr),
    .i_ram_wdata(ram_wdata),
    .o_ram_rdata(ram_rdata)
  );

  wb_regs u_wb_regs (
    .i_ad_clk    (i_ad_clk),
    .i_rst       (i_rst),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .host_bus    (host_bus),
    .i_done      (done),
    .i_measure   (measure),
    .o_trig_level(trig_level),
    .o_trig_edge (trig_edge),
    .o_deci_rate (deci_rate),
    .o_arm       (arm),
    .o_stop      (stop)
  );

  assign o_capture_done = done;

endmodule

// ==== dv/dso_tests.svh ====
// dso directed tests
`ifndef DSO_TESTS_SVH
`define DSO_TESTS_SVH

function automatic measure_t frame_measure();
  measure_t m;
  m.max = exp_frame[0];
  m.min = exp_frame[0];
  for (int k = 1; k < `DSO_CAPTURE_DEPTH; k++) begin
    if (exp_frame[k] > m.max) m.max = exp_frame[k];
    if (exp_frame[k] < m.min) m.min = exp_frame[k];
  end
  m.vpp = m.max - m.min;
  return m;
endfunction

task automatic ramp_frame(input sample_t first, input int step);
  for (int k = 0; k < `DSO_CAPTURE_DEPTH; k++) begin
    exp_frame[k] = first + sample_t'(k * step);  // wraps like the adc code
  end
endtask

task automatic read_frame();
  logic [31:0] d;
  for (int k = 0; k < `DSO_CAPTURE_DEPTH; k++) begin
    wb_read(9'(`DSO_BUF_BASE + k), d);
    frame_buf[k] = d[7:0];
  end
endtask

task automatic check_frame();
  logic [31:0] d;
  for (int k = 0; k < `DSO_CAPTURE_DEPTH; k++) begin
    check_sample(frame_buf[k], exp_frame[k], $sformatf("buffer word %0d", k));
  end
  wb_read(`DSO_REG_MEASURE, d);
  check_measure(measure_t'(d[23:0]), frame_measure(), "MEASURE");
endtask

task automatic start_capture(input sample_t level, input trig_edge_e edge_sel);
  wb_write(`DSO_REG_TRIG_LEVEL, {24'd0, level});
  wb_write(`DSO_REG_CTRL, {30'd0, edge_sel, 1'b1});  // run set arms
endtask

task automatic test_reset_state();
  logic [31:0] d;
  check_word({31'd0, capture_done}, 32'd0, "capture done after reset");
  for (int a = 0; a <= int'(`DSO_REG_MEASURE) + 1; a++) begin  // last one unmapped
    wb_read(9'(a), d);
    check_word(d, 32'd0, $sformatf("register %0d after reset", a));
  end
endtask

task automatic test_reg_readback();
  logic [31:0] d;
  wb_write(`DSO_REG_TRIG_LEVEL, 32'hffff_ff5a);
  wb_read(`DSO_REG_TRIG_LEVEL, d);
  check_word(d, 32'hffff_ff5a & 32'h0000_00ff, "TRIG_LEVEL readback");
  wb_write(`DSO_REG_DECI_RATE, 32'h1234_5678);
  wb_read(`DSO_REG_DECI_RATE, d);
  check_word(d, 32'h1234_5678 & 32'h0000_03ff, "DECI_RATE readback");
  wb_write(`DSO_REG_CTRL, 32'hffff_fffe);  // edge only, run stays clear
  wb_read(`DSO_REG_CTRL, d);
  check_word(d, 32'hffff_fffe & 32'h0000_0003, "CTRL readback");
  wb_write(`DSO_REG_CTRL, 32'd0);
  wb_write(`DSO_REG_DECI_RATE, 32'd0);
endtask

task automatic test_rise_trigger();
  sample_t     level;
  logic [31:0] d;
  level = sample_t'(1 + $urandom % 255);  // zero has no sample below it
  set_ramp(1);
  start_capture(level, EDGE_RISE);
  wait_done();
  wb_read(`DSO_REG_STATUS, d);
  check_word(d, 32'd1, "STATUS after frame");
  wb_read(`DSO_REG_CTRL, d);
  check_word(d, 32'd0, "CTRL after frame");
  ramp_frame(level, 1);
  read_frame();
  check_frame();
endtask

task automatic test_fall_trigger();
  sample_t level;
  level = sample_t'(1 + $urandom % 255);
  set_ramp(-1);
  start_capture(level, EDGE_FALL);
  wait_done();
  ramp_frame(level - 8'd1, -1);
  read_frame();
  check_frame();
endtask

task automatic test_decimation();
  sample_t    level;
  deci_rate_t rate;
  rate  = deci_rate_t'(1 + $urandom % 8);
  level = sample_t'(16 + $urandom % 232);  // window level..level+rate stays below 256
  set_ramp(1);
  wb_write(`DSO_REG_DECI_RATE, {22'd0, rate});
  start_capture(level, EDGE_RISE);
  wait_done();
  read_frame();
  if (frame_buf[0] < level || int'(frame_buf[0]) > int'(level) + int'(rate)) begin
    $display("FAILED at %0t: buffer word 0 is %0d, expected %0d to %0d", $time,
             frame_buf[0], level, int'(level) + int'(rate));
    abort_run();
  end
  ramp_frame(frame_buf[0], int'(rate) + 1);
  check_frame();
  wb_write(`DSO_REG_DECI_RATE, 32'd0);
endtask

task automatic test_stop_rearm();
  sample_t     level;
  logic [31:0] d;
  int          n;
  level = sample_t'(1 + $urandom % 255);
  set_ramp(0);  // frozen input cannot cross
  start_capture(level, EDGE_RISE);
  wb_write(`DSO_REG_CTRL, 32'd0);
  set_ramp(1);
  repeat (2000) begin
    @(negedge clk);
    check_word({31'd0, capture_done}, 32'd0, "capture done after stop");
  end
  start_capture(level, EDGE_RISE);
  n = 0;
  while (!capture_done && n < 1000) begin  // host reads compete with capture writes
    wb_read(9'(`DSO_BUF_BASE + n % `DSO_CAPTURE_DEPTH), d);
    n++;
  end
  wait_done();
  ramp_frame(level, 1);
  read_frame();
  check_frame();
endtask

`endif

// ==== dv/dso_tb.sv ====
// dso core testbench
`timescale 1ns/1ps
`include "dso_macros.svh"

module dso_tb import dso_pkg::*; ();

  localparam int WB_TIMEOUT   = 1000;   // cycles per bus access
  localparam int DONE_TIMEOUT = 20000;  // cycles until a frame completes

  logic        clk;
  logic        rst;
  sample_t     ad_data;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [8:0]  wb_adr;
  logic [31:0] wb_dat;
  logic [31:0] rd_dat;
  logic        wb_ack;
  logic        capture_done;
  int          ramp_step;                          // added to the adc code each cycle
  int unsigned seed;
  sample_t     frame_buf [`DSO_CAPTURE_DEPTH];     // words read back
  sample_t     exp_frame [`DSO_CAPTURE_DEPTH];

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // adc ramp source
  initial begin
    ad_data = '0;
    forever begin
      @(negedge clk);
      ad_data = ad_data + sample_t'(ramp_step);
    end
  end

  dso_core dso_core_inst (
    .i_ad_clk      (clk),
    .i_rst         (rst),
    .i_ad_data     (ad_data),
    .i_wb_cyc      (wb_cyc),
    .i_wb_stb      (wb_stb),
    .i_wb_we       (wb_we),
    .i_wb_adr      (wb_adr),
    .i_wb_dat      (wb_dat),
    .o_wb_dat      (rd_dat),
    .o_wb_ack      (wb_ack),
    .o_capture_done(capture_done)
  );

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_measure(input measure_t got, input measure_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s max/min/vpp %0d/%0d/%0d, expected %0d/%0d/%0d", $time,
               what, got.max, got.min, got.vpp, exp.max, exp.min, exp.vpp);
      abort_run();
    end
  endtask

  // one classic cycle, held until ack
  task automatic wb_access(input logic we, input logic [8:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
    int n;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < WB_TIMEOUT);
    if (!wb_ack) begin
      $display("no wishbone ack for address %0d within %0d cycles", adr, WB_TIMEOUT);
      abort_run();
    end
    rdat = rd_dat;
    @(negedge clk);  // hold through the ack edge
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [8:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [8:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'd0, dat);
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!capture_done && n < DONE_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!capture_done) begin
      $display("capture done did not rise within %0d cycles", DONE_TIMEOUT);
      abort_run();
    end
  endtask

  task automatic set_ramp(input int step);
    @(posedge clk);  // away from the ramp update edge
    ramp_step = step;
  endtask

  `include "dso_tests.svh"

  initial begin
    seed      = 32'h34ab_2d22;
    void'($urandom(seed));
    rst       = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat    = '0;
    ramp_step = 1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    test_reset_state();
    test_reg_readback();
    test_rise_trigger();
    test_fall_trigger();
    test_decimation();
    test_stop_rearm();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verilog
+incdir+dv
verilog/dso_pkg.sv
verilog/mem_req_if.sv
verilog/decimator.sv
verilog/trig_capture.sv
verilog/param_measure.sv
verilog/sample_arbiter.sv
verilog/sample_ram.sv
verilog/wb_regs.sv
verilog/dso_core.sv
dv/dso_tb.sv
